/* tb.f */
hdl/yuv_pkg.sv
hdl/const_mult8.sv
hdl/luma_path.sv
hdl/chroma_path.sv
hdl/yuv_output_stage.sv
hdl/rgb2yuv.sv
tb/tb_rgb2yuv.sv

/* run.sh */
#!/bin/sh
# build and run the rgb2yuv testbench with Verilator
rm -f sim.log
verilator --binary --timing --top-module tb_rgb2yuv -f tb.f -o sim_rgb2yuv \
    && ./obj_dir/sim_rgb2yuv | tee sim.log \
    || { echo "build or run failed"; exit 1; }
grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "no result in log"; exit 1; }
exit 0

/* tb/tb_rgb2yuv.sv */
// rgb to yuv testbench
`timescale 1ns/10ps

module tb_rgb2yuv;

    localparam int total_pixels = 8 + 300 + 300 + 200;
    localparam int max_cycles   = 4 * total_pixels + 200;

    logic                clk;
    logic                rst_n;
    yuv_pkg::rgb_pixel_t in_pixel;
    logic                in_valid;
    logic                in_ready;
    yuv_pkg::yuv_pixel_t out_pixel;
    logic                out_valid;
    logic                out_ready;

    yuv_pkg::yuv_pixel_t exp_q[$];
    yuv_pkg::yuv_pixel_t held_pixel;
    logic                hold_pending;
    logic                rand_ready;   // out_ready random when set
    logic                no_gap_check;
    int                  cycle_cnt;
    int                  err_cnt;
    int                  err_start;
    int                  pass_cnt;
    int                  fail_cnt;
    int                  test_len;
    int                  test_accepts;
    int                  test_outs;
    int                  full_seen;

    rgb2yuv u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_pixel  (in_pixel),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_pixel (out_pixel),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // expected pixel from upper bytes of the wrapped sums
    function automatic yuv_pkg::yuv_pixel_t ref_yuv(input yuv_pkg::rgb_pixel_t p);
        logic [15:0] r;
        logic [15:0] g;
        logic [15:0] b;
        logic [15:0] y;
        logic [15:0] u;
        logic [15:0] v;
        yuv_pkg::yuv_pixel_t res;
        r = {8'd0, p.r};
        g = {8'd0, p.g};
        b = {8'd0, p.b};
        y = 16'd66 * r + 16'd129 * g + 16'd25 * b + 16'd128;
        u = 16'd112 * b - 16'd38 * r - 16'd74 * g + 16'd128;
        v = 16'd112 * r - 16'd94 * g - 16'd18 * b + 16'd128;
        res.y = y[15:8];
        res.u = u[15:8];
        res.v = v[15:8];
        return res;
    endfunction

    function automatic yuv_pkg::rgb_pixel_t rand_pixel();
        yuv_pkg::rgb_pixel_t p;
        p.r = 8'($urandom);
        p.g = 8'($urandom);
        p.b = 8'($urandom);
        return p;
    endfunction

    always @(negedge clk) begin
        out_ready = rand_ready ? 1'($urandom) : 1'b1;
    end

    // scoreboard and protocol checks on pre-edge values
    always @(posedge clk) begin
        int in_flight;
        yuv_pkg::yuv_pixel_t exp;
        if (rst_n) begin
            in_flight = exp_q.size();
            if (in_ready !== ((in_flight < 2) || out_ready)) begin
                $display("[ERROR] %0t ns: in_ready %0b with %0d pixels inside",
                         $time, in_ready, in_flight);
                err_cnt++;
            end
            if (!in_ready) full_seen++;
            if (hold_pending && (!out_valid || out_pixel !== held_pixel)) begin
                $display("[ERROR] %0t ns: output changed while stalled", $time);
                err_cnt++;
            end
            if (no_gap_check && test_outs > 0 && test_outs < test_len && !out_valid) begin
                $display("[ERROR] %0t ns: gap in output stream", $time);
                err_cnt++;
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(ref_yuv(in_pixel));
                test_accepts++;
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("[ERROR] %0t ns: output with no pixel pending", $time);
                    err_cnt++;
                end else begin
                    exp = exp_q.pop_front();
                    if (out_pixel !== exp) begin
                        $display("[ERROR] %0t ns: expected yuv %06h, got %06h",
                                 $time, exp, out_pixel);
                        err_cnt++;
                    end
                end
                test_outs++;
            end
            hold_pending = out_valid && !out_ready;
            held_pixel   = out_pixel;
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < max_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", max_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic send_pixel(input yuv_pkg::rgb_pixel_t p);
        in_pixel = p;
        in_valid = 1'b1;
        @(posedge clk);
        while (!in_ready) @(posedge clk);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic set_ready_mode(input logic rnd);
        @(posedge clk);
        rand_ready = rnd;
        @(negedge clk);
    endtask

    task automatic start_test(input int len);
        test_len     = len;
        test_accepts = 0;
        test_outs    = 0;
        full_seen    = 0;
        err_start    = err_cnt;
    endtask

    task automatic end_test(input string name);
        while (exp_q.size() != 0) @(negedge clk);
        repeat (2) @(negedge clk);
        if (test_outs != test_accepts) begin
            $display("%s: %0d pixels accepted but %0d came out", name, test_accepts, test_outs);
            err_cnt++;
        end
        if (err_cnt == err_start) begin
            pass_cnt++;
            $display("test %s passed, %0d pixels", name, test_outs);
        end else begin
            fail_cnt++;
            $display("test %s failed, %0d errors", name, err_cnt - err_start);
        end
    endtask

    initial begin
        yuv_pkg::rgb_pixel_t corners[8];
        void'($urandom(32'h61ea7391));
        rst_n        = 1'b0;
        in_pixel     = '0;
        in_valid     = 1'b0;
        out_ready    = 1'b1;
        rand_ready   = 1'b0;
        no_gap_check = 1'b0;
        hold_pending = 1'b0;
        held_pixel   = '0;
        err_cnt      = 0;
        pass_cnt     = 0;
        fail_cnt     = 0;
        start_test(0);

        // reset state
        @(posedge clk);
        @(negedge clk);
        if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
            $display("[ERROR] %0t ns: bad handshake state during reset", $time);
            err_cnt++;
        end
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
            $display("[ERROR] %0t ns: bad handshake state after reset", $time);
            err_cnt++;
        end
        end_test("reset");

        // yellow and cyan drive u and v below zero
        corners[0] = '{r: 8'h00, g: 8'h00, b: 8'h00};
        corners[1] = '{r: 8'hff, g: 8'hff, b: 8'hff};
        corners[2] = '{r: 8'hff, g: 8'h00, b: 8'h00};
        corners[3] = '{r: 8'h00, g: 8'hff, b: 8'h00};
        corners[4] = '{r: 8'h00, g: 8'h00, b: 8'hff};
        corners[5] = '{r: 8'hff, g: 8'hff, b: 8'h00};
        corners[6] = '{r: 8'h00, g: 8'hff, b: 8'hff};
        corners[7] = '{r: 8'hff, g: 8'h00, b: 8'hff};
        start_test(8);
        for (int i = 0; i < 8; i++) send_pixel(corners[i]);
        end_test("corners");

        start_test(300);
        no_gap_check = 1'b1;
        for (int i = 0; i < 300; i++) send_pixel(rand_pixel());
        end_test("streaming");
        no_gap_check = 1'b0;

        start_test(300);
        set_ready_mode(1'b1);
        for (int i = 0; i < 300; i++) send_pixel(rand_pixel());
        set_ready_mode(1'b0);
        if (full_seen == 0) begin
            $display("backpressure: in_ready never went low");
            err_cnt++;
        end
        end_test("backpressure");

        start_test(200);
        set_ready_mode(1'b1);
        for (int i = 0; i < 200; i++) begin
            repeat ($urandom_range(0, 2)) @(negedge clk);
            send_pixel(rand_pixel());
        end
        set_ready_mode(1'b0);
        end_test("gaps");

        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* hdl/rgb2yuv.sv */
// rgb to yuv converter top
`timescale 1ns/10ps

module rgb2yuv #(
    parameter yuv_pkg::coef_triple_t y_coef = yuv_pkg::y_coef_default,
    parameter yuv_pkg::coef_triple_t u_coef = yuv_pkg::u_coef_default,
    parameter yuv_pkg::coef_triple_t v_coef = yuv_pkg::v_coef_default
) (
    input  logic                clk,
    input  logic                rst_n,
    input  yuv_pkg::rgb_pixel_t in_pixel,
    input  logic                in_valid,
    output logic                in_ready,
    output yuv_pkg::yuv_pixel_t out_pixel,
    output logic                out_valid,
    input  logic                out_ready
);

    logic        load_s1;
    logic [15:0] y_sum;
    logic [15:0] u_sum;
    logic [15:0] v_sum;

    luma_path #(.coef(y_coef)) u_luma (
        .clk     (clk),
        .rst_n   (rst_n),
        .load_s1 (load_s1),
        .pixel   (in_pixel),
        .y_sum   (y_sum)
    );

    chroma_path #(
        .u_coef (u_coef),
        .v_coef (v_coef)
    ) u_chroma (
        .clk     (clk),
        .rst_n   (rst_n),
        .load_s1 (load_s1),
        .pixel   (in_pixel),
        .u_sum   (u_sum),
        .v_sum   (v_sum)
    );

    yuv_output_stage u_out (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .load_s1   (load_s1),
        .y_sum     (y_sum),
        .u_sum     (u_sum),
        .v_sum     (v_sum),
        .out_pixel (out_pixel),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

/* hdl/yuv_output_stage.sv */
// pipeline control and output register
`timescale 1ns/10ps

module yuv_output_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    output logic                in_ready,
    output logic                load_s1,
    input  logic [15:0]         y_sum,
    input  logic [15:0]         u_sum,
    input  logic [15:0]         v_sum,
    output yuv_pkg::yuv_pixel_t out_pixel,
    output logic                out_valid,
    input  logic                out_ready
);

    logic s1_valid; // path registers hold a pixel
    logic advance;

    // stage 1 moves when the output slot is free or draining
    assign advance  = s1_valid && (!out_valid || out_ready);
    assign in_ready = !s1_valid || advance;
    assign load_s1  = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else if (load_s1) begin
            s1_valid <= 1'b1;
        end else if (advance) begin
            s1_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0; // taken downstream
        end
    end

    // upper bytes of the sums form the output pixel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_pixel <= '0;
        end else if (advance) begin
            out_pixel.y <= y_sum[15:8];
            out_pixel.u <= u_sum[15:8];
            out_pixel.v <= v_sum[15:8];
        end
    end

endmodule

/* hdl/chroma_path.sv */
// chroma u and v weighted sums
`timescale 1ns/10ps

module chroma_path #(
    parameter yuv_pkg::coef_triple_t u_coef = yuv_pkg::u_coef_default,
    parameter yuv_pkg::coef_triple_t v_coef = yuv_pkg::v_coef_default
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load_s1,
    input  yuv_pkg::rgb_pixel_t pixel,
    output logic [15:0]         u_sum,
    output logic [15:0]         v_sum
);

    logic [15:0] r_u_prod, g_u_prod, b_u_prod;
    logic [15:0] r_v_prod, g_v_prod, b_v_prod;
    logic [15:0] u_next;
    logic [15:0] v_next;

    // u products
    const_mult8 #(.coef(u_coef.r_w)) u_mult_r_u (
        .a (pixel.r),
        .p (r_u_prod)
    );

    const_mult8 #(.coef(u_coef.g_w)) u_mult_g_u (
        .a (pixel.g),
        .p (g_u_prod)
    );

    const_mult8 #(.coef(u_coef.b_w)) u_mult_b_u (
        .a (pixel.b),
        .p (b_u_prod)
    );

    // v products
    const_mult8 #(.coef(v_coef.r_w)) u_mult_r_v (
        .a (pixel.r),
        .p (r_v_prod)
    );

    const_mult8 #(.coef(v_coef.g_w)) u_mult_g_v (
        .a (pixel.g),
        .p (g_v_prod)
    );

    const_mult8 #(.coef(v_coef.b_w)) u_mult_b_v (
        .a (pixel.b),
        .p (b_v_prod)
    );

    // modulo 2^16, negative sums wrap
    assign u_next = b_u_prod - r_u_prod - g_u_prod + yuv_pkg::round_offset;
    assign v_next = r_v_prod - g_v_prod - b_v_prod + yuv_pkg::round_offset;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            u_sum <= 16'd0;
            v_sum <= 16'd0;
        end else if (load_s1) begin
            u_sum <= u_next;
            v_sum <= v_next;
        end
    end

endmodule

/* hdl/luma_path.sv */
// luma weighted sum
`timescale 1ns/10ps

module luma_path #(
    parameter yuv_pkg::coef_triple_t coef = yuv_pkg::y_coef_default
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load_s1,
    input  yuv_pkg::rgb_pixel_t pixel,
    output logic [15:0]         y_sum
);

    logic [15:0] r_prod;
    logic [15:0] g_prod;
    logic [15:0] b_prod;
    logic [15:0] sum_next;

    const_mult8 #(.coef(coef.r_w)) u_mult_r (
        .a (pixel.r),
        .p (r_prod)
    );

    const_mult8 #(.coef(coef.g_w)) u_mult_g (
        .a (pixel.g),
        .p (g_prod)
    );

    const_mult8 #(.coef(coef.b_w)) u_mult_b (
        .a (pixel.b),
        .p (b_prod)
    );

    assign sum_next = r_prod + g_prod + b_prod + yuv_pkg::round_offset; // wraps at 16 bits

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            y_sum <= 16'd0;
        end else if (load_s1) begin
            y_sum <= sum_next;
        end
    end

endmodule

/* hdl/const_mult8.sv */
// constant coefficient multiplier
`timescale 1ns/10ps

module const_mult8 #(
    parameter logic [7:0] coef = 8'd1
) (
    input  logic [7:0]  a,
    output logic [15:0] p
);

    logic [15:0] pp      [8];
    logic [15:0] sum_row [1:7];
    logic [15:0] cry_row [1:7];
    logic [15:0] maj     [1:7];

    genvar i;

    // one partial product row per coef bit
    generate
        for (i = 0; i < 8; i++) begin : g_pp
            assign pp[i] = coef[i] ? ({8'd0, a} << i) : 16'd0;
        end
    endgenerate

    // first row is a half adder
    assign sum_row[1] = pp[0] ^ pp[1];
    assign maj[1]     = pp[0] & pp[1];
    assign cry_row[1] = {maj[1][14:0], 1'b0};

    // carry-save rows fold in one more partial product each
    generate
        for (i = 2; i < 8; i++) begin : g_csa
            assign sum_row[i] = sum_row[i-1] ^ cry_row[i-1] ^ pp[i];
            assign maj[i]     = (sum_row[i-1] & cry_row[i-1])
                              | (sum_row[i-1] & pp[i])
                              | (cry_row[i-1] & pp[i]);
            assign cry_row[i] = {maj[i][14:0], 1'b0}; // carries move up one column
        end
    endgenerate

    // final ripple add of sum and carry vectors
    always_comb begin
        logic carry;
        carry = 1'b0;
        for (int k = 0; k < 16; k++) begin
            p[k]  = sum_row[7][k] ^ cry_row[7][k] ^ carry;
            carry = (sum_row[7][k] & cry_row[7][k])
                  | (sum_row[7][k] & carry)
                  | (cry_row[7][k] & carry);
        end
    end

endmodule

/* hdl/yuv_pkg.sv */
// rgb to yuv shared types

package yuv_pkg;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_pixel_t;

    typedef struct packed {
        logic [7:0] y;
        logic [7:0] u;
        logic [7:0] v;
    } yuv_pixel_t;

    // weights of one output component
    typedef struct packed {
        logic [7:0] r_w;
        logic [7:0] g_w;
        logic [7:0] b_w;
    } coef_triple_t;

    localparam coef_triple_t y_coef_default = '{
        r_w: 8'd66,
        g_w: 8'd129,
        b_w: 8'd25
    };

    // r and g terms are subtracted for u
    localparam coef_triple_t u_coef_default = '{
        r_w: 8'd38,
        g_w: 8'd74,
        b_w: 8'd112
    };

    // g and b terms are subtracted for v
    localparam coef_triple_t v_coef_default = '{
        r_w: 8'd112,
        g_w: 8'd94,
        b_w: 8'd18
    };

    localparam logic [15:0] round_offset = 16'd128; // half lsb of the output byte

endpackage
